/* design/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int INST_WIDTH        = 32;
    localparam int REG_ADDR_WIDTH    = 5;
    localparam int DEFAULT_XLEN      = 64;
    localparam int DEFAULT_CNT_WIDTH = 16;

    typedef logic [INST_WIDTH-1:0]     inst_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    localparam inst_t EBREAK_INST = 32'h0010_0073;

    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_BRANCH    = 7'b1100011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU    // branch compares
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG     = 2'd0,
        SRC_IMM     = 2'd1,
        SRC_PC_IMM  = 2'd2,
        SRC_PC_FOUR = 2'd3   // link value for jal / jalr
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_NONE    = 3'd0,
        IMM_I       = 3'd1,
        IMM_I_SHIFT = 3'd2,
        IMM_S       = 3'd3,
        IMM_B       = 3'd4,
        IMM_U       = 3'd5,
        IMM_J       = 3'd6
    } imm_sel_e;

    typedef enum logic [1:0] {
        MEM_BYTE   = 2'd0,
        MEM_HALF   = 2'd1,
        MEM_WORD   = 2'd2,
        MEM_DOUBLE = 2'd3   // same order as funct3[1:0]
    } mem_size_e;

    typedef struct packed {
        logic      branch;
        logic      jump;
        logic      jalr;
        logic      reg_wen;
        reg_addr_t reg_waddr;
        reg_addr_t reg1_raddr;
        reg_addr_t reg2_raddr;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        imm_sel_e  imm_sel;
        logic      word_op;        // 32-bit result, sign-extended
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic [7:0] wmask;
        logic      is_mul;
    } decode_ctrl_t;

endpackage

/* design/decode_bus_if.sv */
`timescale 1ns/1ps

interface decode_bus_if #(
    parameter int XLEN = rv_decode_pkg::DEFAULT_XLEN
);

    logic                        valid;
    rv_decode_pkg::decode_ctrl_t ctrl;
    logic [XLEN-1:0]             imm;
    logic                        illegal;
    logic                        ebreak;

    modport dec (
        output valid, ctrl, illegal, ebreak
    );

    modport immg (
        input  ctrl,
        output imm
    );

    modport sink (
        input valid, ctrl, imm, illegal, ebreak
    );

endinterface

/* design/decode_config.sv */
`timescale 1ns/1ps

module decode_config #(
    parameter int CNT_WIDTH = rv_decode_pkg::DEFAULT_CNT_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_wen,
    input  logic                 cfg_m_enable,
    input  logic                 out_valid,       // registered stage outputs
    input  logic                 illegal,
    output logic                 m_enable,
    output logic [CNT_WIDTH-1:0] illegal_count
);

    logic count_hit;
    logic count_full;

    assign count_hit  = out_valid && illegal;
    assign count_full = (illegal_count == {CNT_WIDTH{1'b1}});

    // M extension on out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            m_enable <= 1'b1;
        end else if (cfg_wen) begin
            m_enable <= cfg_m_enable;   // seen by the next decode
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            illegal_count <= '0;
        end else if (count_hit && !count_full) begin
            illegal_count <= illegal_count + 1'b1;   // saturates
        end
    end

endmodule

/* design/ctrl_decode.sv */
`timescale 1ns/1ps

module ctrl_decode (
    input  logic                 inst_valid,
    input  rv_decode_pkg::inst_t inst,
    input  logic                 m_enable,
    decode_bus_if.dec            bus
);

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    rv_decode_pkg::reg_addr_t    rd;
    rv_decode_pkg::reg_addr_t    rs1;
    rv_decode_pkg::reg_addr_t    rs2;
    logic                        op32;
    logic                        word_f3_ok;
    logic [6:0]                  shift_hi;
    logic                        bad;
    logic                        is_ebreak;
    rv_decode_pkg::decode_ctrl_t ctrl;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign op32 = (opcode == rv_decode_pkg::OPC_OP_32) ||
                  (opcode == rv_decode_pkg::OPC_OP_IMM_32);
    assign word_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
    assign shift_hi   = op32 ? funct7 : {inst[31:26], 1'b0};   // 6-bit shamt on rv64

    always_comb begin
        ctrl = '0;
        bad  = 1'b0;
        case (opcode)
            rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_OP_32: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.word_op    = op32;
                if (funct7 == 7'b0000001) begin
                    bad = !m_enable;
                    case (funct3)
                        3'b000: begin
                            ctrl.alu_op = rv_decode_pkg::ALU_MUL;
                            ctrl.is_mul = 1'b1;
                        end
                        3'b100: ctrl.alu_op = rv_decode_pkg::ALU_DIV;
                        3'b101: ctrl.alu_op = rv_decode_pkg::ALU_DIVU;
                        3'b110: ctrl.alu_op = rv_decode_pkg::ALU_REM;
                        3'b111: ctrl.alu_op = rv_decode_pkg::ALU_REMU;
                        default: bad = 1'b1;   // no mulh family
                    endcase
                end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    case (funct3)
                        3'b000: ctrl.alu_op = funct7[5] ? rv_decode_pkg::ALU_SUB
                                                        : rv_decode_pkg::ALU_ADD;
                        3'b001: ctrl.alu_op = rv_decode_pkg::ALU_SLL;
                        3'b010: ctrl.alu_op = rv_decode_pkg::ALU_SLT;
                        3'b011: ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                        3'b100: ctrl.alu_op = rv_decode_pkg::ALU_XOR;
                        3'b101: ctrl.alu_op = funct7[5] ? rv_decode_pkg::ALU_SRA
                                                        : rv_decode_pkg::ALU_SRL;
                        3'b110: ctrl.alu_op = rv_decode_pkg::ALU_OR;
                        default: ctrl.alu_op = rv_decode_pkg::ALU_AND;
                    endcase
                    // funct7[5] only selects sub and sra
                    if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101) begin
                        bad = 1'b1;
                    end
                    if (op32 && !word_f3_ok) begin
                        bad = 1'b1;
                    end
                end else begin
                    bad = 1'b1;
                end
            end
            rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP_IMM_32: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;
                ctrl.alu_src    = rv_decode_pkg::SRC_IMM;
                ctrl.imm_sel    = rv_decode_pkg::IMM_I;
                ctrl.word_op    = op32;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_decode_pkg::ALU_ADD;
                    3'b001: begin
                        ctrl.alu_op  = rv_decode_pkg::ALU_SLL;
                        ctrl.imm_sel = rv_decode_pkg::IMM_I_SHIFT;
                        bad          = (shift_hi != 7'b0000000);
                    end
                    3'b010: ctrl.alu_op = rv_decode_pkg::ALU_SLT;
                    3'b011: ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_op = rv_decode_pkg::ALU_XOR;
                    3'b101: begin
                        ctrl.alu_op  = inst[30] ? rv_decode_pkg::ALU_SRA
                                                : rv_decode_pkg::ALU_SRL;
                        ctrl.imm_sel = rv_decode_pkg::IMM_I_SHIFT;
                        bad = (shift_hi != 7'b0000000) && (shift_hi != 7'b0100000);
                    end
                    3'b110: ctrl.alu_op = rv_decode_pkg::ALU_OR;
                    default: ctrl.alu_op = rv_decode_pkg::ALU_AND;
                endcase
                if (op32 && !word_f3_ok) begin
                    bad = 1'b1;
                end
            end
            rv_decode_pkg::OPC_LOAD: begin
                ctrl.reg_wen       = 1'b1;
                ctrl.reg_waddr     = rd;
                ctrl.reg1_raddr    = rs1;
                ctrl.alu_src       = rv_decode_pkg::SRC_IMM;
                ctrl.imm_sel       = rv_decode_pkg::IMM_I;
                ctrl.mem_read      = 1'b1;
                ctrl.mem_size      = rv_decode_pkg::mem_size_e'(funct3[1:0]);
                ctrl.load_unsigned = funct3[2];
                bad                = (funct3 == 3'b111);   // no ldu
            end
            rv_decode_pkg::OPC_STORE: begin
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.alu_src    = rv_decode_pkg::SRC_IMM;
                ctrl.imm_sel    = rv_decode_pkg::IMM_S;
                ctrl.mem_write  = 1'b1;
                ctrl.mem_size   = rv_decode_pkg::mem_size_e'(funct3[1:0]);
                case (funct3[1:0])
                    2'b00: ctrl.wmask = 8'h01;
                    2'b01: ctrl.wmask = 8'h03;
                    2'b10: ctrl.wmask = 8'h0f;
                    default: ctrl.wmask = 8'hff;
                endcase
                bad = funct3[2];
            end
            rv_decode_pkg::OPC_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.alu_src   = rv_decode_pkg::SRC_PC_FOUR;
                ctrl.imm_sel   = rv_decode_pkg::IMM_J;
            end
            rv_decode_pkg::OPC_JALR: begin
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;   // target base
                ctrl.alu_src    = rv_decode_pkg::SRC_PC_FOUR;
                ctrl.imm_sel    = rv_decode_pkg::IMM_I;
                bad             = (funct3 != 3'b000);
            end
            rv_decode_pkg::OPC_LUI: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.alu_src   = rv_decode_pkg::SRC_IMM;   // x0 + imm
                ctrl.imm_sel   = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OPC_AUIPC: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.alu_src   = rv_decode_pkg::SRC_PC_IMM;
                ctrl.imm_sel   = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                ctrl.branch     = 1'b1;
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.imm_sel    = rv_decode_pkg::IMM_B;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_decode_pkg::ALU_EQ;
                    3'b001: ctrl.alu_op = rv_decode_pkg::ALU_NE;
                    3'b100: ctrl.alu_op = rv_decode_pkg::ALU_LT;
                    3'b101: ctrl.alu_op = rv_decode_pkg::ALU_GE;
                    3'b110: ctrl.alu_op = rv_decode_pkg::ALU_LTU;
                    3'b111: ctrl.alu_op = rv_decode_pkg::ALU_GEU;
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;   // ebreak lands here too
        endcase
        if (bad) begin
            ctrl = '0;
        end
    end

    assign is_ebreak   = (inst == rv_decode_pkg::EBREAK_INST);
    assign bus.valid   = inst_valid;
    assign bus.ctrl    = ctrl;
    assign bus.illegal = bad && !is_ebreak;
    assign bus.ebreak  = is_ebreak;

endmodule

/* design/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen #(
    parameter int XLEN = rv_decode_pkg::DEFAULT_XLEN
) (
    input  rv_decode_pkg::inst_t inst,
    decode_bus_if.immg           bus
);

    logic [31:0] imm_i;
    logic [31:0] imm_sh;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm32;

    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_sh = {26'b0, inst[25:20]};   // shamt, never negative
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u  = {inst[31:12], 12'b0};
    assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (bus.ctrl.imm_sel)
            rv_decode_pkg::IMM_I:       imm32 = imm_i;
            rv_decode_pkg::IMM_I_SHIFT: imm32 = imm_sh;
            rv_decode_pkg::IMM_S:       imm32 = imm_s;
            rv_decode_pkg::IMM_B:       imm32 = imm_b;
            rv_decode_pkg::IMM_U:       imm32 = imm_u;
            rv_decode_pkg::IMM_J:       imm32 = imm_j;
            default:                    imm32 = 32'b0;
        endcase
    end

    // bit 31 carries the sign for every format
    assign bus.imm = XLEN'($signed(imm32));

endmodule

/* design/decode_out_reg.sv */
`timescale 1ns/1ps

module decode_out_reg #(
    parameter int XLEN = rv_decode_pkg::DEFAULT_XLEN
) (
    input  logic                        clk,
    input  logic                        reset,
    decode_bus_if.sink                  bus,
    output logic                        out_valid,
    output rv_decode_pkg::decode_ctrl_t ctrl_q,
    output logic [XLEN-1:0]             imm_q,
    output logic                        illegal_q,
    output logic                        ebreak_q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q    <= '0;
            imm_q     <= '0;
            illegal_q <= 1'b0;
            ebreak_q  <= 1'b0;
        end else if (bus.valid) begin
            ctrl_q    <= bus.ctrl;
            imm_q     <= bus.imm;
            illegal_q <= bus.illegal;
            ebreak_q  <= bus.ebreak;
        end else begin
            // idle cycle, keep outputs quiet
            ctrl_q    <= '0;
            imm_q     <= '0;
            illegal_q <= 1'b0;
            ebreak_q  <= 1'b0;
        end
    end

endmodule

/* design/rv_decode_top.sv */
`timescale 1ns/1ps

module rv_decode_top #(
    parameter int XLEN      = rv_decode_pkg::DEFAULT_XLEN,
    parameter int CNT_WIDTH = rv_decode_pkg::DEFAULT_CNT_WIDTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  rv_decode_pkg::inst_t      inst,
    input  logic                      cfg_wen,
    input  logic                      cfg_m_enable,
    output logic                      out_valid,
    output logic                      branch,
    output logic                      jump,
    output logic                      jalr,
    output logic                      reg_wen,
    output rv_decode_pkg::reg_addr_t  reg_waddr,
    output rv_decode_pkg::reg_addr_t  reg1_raddr,
    output rv_decode_pkg::reg_addr_t  reg2_raddr,
    output rv_decode_pkg::alu_op_e    alu_op,
    output rv_decode_pkg::alu_src_e   alu_src,
    output logic [XLEN-1:0]           imm,
    output logic                      word_op,
    output logic                      mem_read,
    output logic                      mem_write,
    output rv_decode_pkg::mem_size_e  mem_size,
    output logic                      load_unsigned,
    output logic [7:0]                wmask,
    output logic                      is_mul,
    output logic                      ebreak,
    output logic                      illegal,
    output logic [CNT_WIDTH-1:0]      illegal_count
);

    rv_decode_pkg::decode_ctrl_t ctrl_q;
    logic                        m_enable;

    decode_bus_if #(.XLEN(XLEN)) dec_bus ();

    decode_config #(.CNT_WIDTH(CNT_WIDTH)) decode_config_inst (
        .clk(clk), .reset(reset),
        .cfg_wen(cfg_wen), .cfg_m_enable(cfg_m_enable),
        .out_valid(out_valid), .illegal(illegal),
        .m_enable(m_enable), .illegal_count(illegal_count)
    );

    ctrl_decode ctrl_decode_inst (
        .inst_valid(inst_valid), .inst(inst), .m_enable(m_enable), .bus(dec_bus.dec)
    );

    imm_gen #(.XLEN(XLEN)) imm_gen_inst (.inst(inst), .bus(dec_bus.immg));

    decode_out_reg #(.XLEN(XLEN)) decode_out_reg_inst (
        .clk(clk), .reset(reset), .bus(dec_bus.sink),
        .out_valid(out_valid), .ctrl_q(ctrl_q), .imm_q(imm),
        .illegal_q(illegal), .ebreak_q(ebreak)
    );

    // registered struct out to flat ports
    assign branch        = ctrl_q.branch;
    assign jump          = ctrl_q.jump;
    assign jalr          = ctrl_q.jalr;
    assign reg_wen       = ctrl_q.reg_wen;
    assign reg_waddr     = ctrl_q.reg_waddr;
    assign reg1_raddr    = ctrl_q.reg1_raddr;
    assign reg2_raddr    = ctrl_q.reg2_raddr;
    assign alu_op        = ctrl_q.alu_op;
    assign alu_src       = ctrl_q.alu_src;
    assign word_op       = ctrl_q.word_op;
    assign mem_read      = ctrl_q.mem_read;
    assign mem_write     = ctrl_q.mem_write;
    assign mem_size      = ctrl_q.mem_size;
    assign load_unsigned = ctrl_q.load_unsigned;
    assign wmask         = ctrl_q.wmask;
    assign is_mul        = ctrl_q.is_mul;

endmodule

/* tests/rv_decode_assertions.sv */
`timescale 1ns/1ps

module rv_decode_assertions #(
    parameter int XLEN = rv_decode_pkg::DEFAULT_XLEN
) (
    input logic            clk,
    input logic            reset,
    input logic            inst_valid,
    input logic            out_valid,
    input logic            illegal,
    input logic            branch,
    input logic            jump,
    input logic            jalr,
    input logic            reg_wen,
    input logic            mem_read,
    input logic            mem_write,
    input logic            is_mul,
    input logic [7:0]      wmask,
    input logic [XLEN-1:0] imm
);

    int unsigned fail_count = 0;   // read by the testbench at the end

    illegal_quiet: assert property (@(posedge clk) disable iff (reset)
        illegal |-> !(branch || jump || jalr || reg_wen || mem_read || mem_write || is_mul)
                    && wmask == 8'h00 && imm == '0)
        else begin
            $error("illegal output with active controls");
            fail_count = fail_count + 1;
        end

    store_no_wen: assert property (@(posedge clk) disable iff (reset) mem_write |-> !reg_wen)
        else begin
            $error("store asserts reg_wen");
            fail_count = fail_count + 1;
        end

    valid_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(inst_valid))
        else begin
            $error("out_valid does not follow inst_valid by one cycle");
            fail_count = fail_count + 1;
        end

endmodule

bind rv_decode_top rv_decode_assertions #(.XLEN(XLEN)) rv_decode_assertions_inst (
    .clk(clk), .reset(reset), .inst_valid(inst_valid), .out_valid(out_valid),
    .illegal(illegal), .branch(branch), .jump(jump), .jalr(jalr), .reg_wen(reg_wen),
    .mem_read(mem_read), .mem_write(mem_write), .is_mul(is_mul), .wmask(wmask), .imm(imm)
);

/* tests/decode_vectors.svh */
// columns: cfg (0 decode, 1 clear m_enable, 2 set m_enable), inst, ctrl, imm, illegal, ebreak
typedef struct packed {
    logic [1:0]                  cfg;
    rv_decode_pkg::inst_t        inst;
    rv_decode_pkg::decode_ctrl_t ctrl;
    logic [63:0]                 imm;
    logic                        illegal;
    logic                        ebreak;
} vec_t;

vec_t vecs[$];

function automatic rv_decode_pkg::decode_ctrl_t rr(input rv_decode_pkg::reg_addr_t rd, rs1, rs2,
        input rv_decode_pkg::alu_op_e op, input logic w, mul);
    rv_decode_pkg::decode_ctrl_t c;
    c = '0;
    c.reg_wen    = 1'b1;
    c.reg_waddr  = rd;
    c.reg1_raddr = rs1;
    c.reg2_raddr = rs2;
    c.alu_op     = op;
    c.word_op    = w;
    c.is_mul     = mul;
    return c;
endfunction

function automatic rv_decode_pkg::decode_ctrl_t ri(input rv_decode_pkg::reg_addr_t rd, rs1,
        input rv_decode_pkg::alu_op_e op, input rv_decode_pkg::imm_sel_e sel, input logic w);
    rv_decode_pkg::decode_ctrl_t c;
    c = '0;
    c.reg_wen    = 1'b1;
    c.reg_waddr  = rd;
    c.reg1_raddr = rs1;
    c.alu_op     = op;
    c.alu_src    = rv_decode_pkg::SRC_IMM;
    c.imm_sel    = sel;
    c.word_op    = w;
    return c;
endfunction

function automatic rv_decode_pkg::decode_ctrl_t ld(input rv_decode_pkg::mem_size_e sz,
        input logic uns);
    rv_decode_pkg::decode_ctrl_t c;
    c = ri(3, 1, rv_decode_pkg::ALU_ADD, rv_decode_pkg::IMM_I, 1'b0);
    c.mem_read      = 1'b1;
    c.mem_size      = sz;
    c.load_unsigned = uns;
    return c;
endfunction

function automatic rv_decode_pkg::decode_ctrl_t st(input rv_decode_pkg::mem_size_e sz,
        input logic [7:0] mask);
    rv_decode_pkg::decode_ctrl_t c;
    c = '0;
    c.reg1_raddr = 1;
    c.reg2_raddr = 2;
    c.alu_src    = rv_decode_pkg::SRC_IMM;
    c.imm_sel    = rv_decode_pkg::IMM_S;
    c.mem_write  = 1'b1;
    c.mem_size   = sz;
    c.wmask      = mask;
    return c;
endfunction

function automatic rv_decode_pkg::decode_ctrl_t ctl(input logic br, jmp, jr,
        input rv_decode_pkg::reg_addr_t rd, rs1, rs2, input rv_decode_pkg::alu_op_e op,
        input rv_decode_pkg::alu_src_e src, input rv_decode_pkg::imm_sel_e sel);
    rv_decode_pkg::decode_ctrl_t c;
    c = '0;
    c.branch     = br;
    c.jump       = jmp;
    c.jalr       = jr;
    c.reg_wen    = (rd != 0);   // branches have no destination
    c.reg_waddr  = rd;
    c.reg1_raddr = rs1;
    c.reg2_raddr = rs2;
    c.alu_op     = op;
    c.alu_src    = src;
    c.imm_sel    = sel;
    return c;
endfunction

function automatic void row(input logic [1:0] cfg, input rv_decode_pkg::inst_t inst,
        input rv_decode_pkg::decode_ctrl_t ctrl, input longint imm, input logic ill, eb);
    vec_t v;
    v = {cfg, inst, ctrl, imm, ill, eb};
    vecs.push_back(v);
endfunction

function automatic void build_table();
    row(0, 32'h002081b3, rr(3, 1, 2, rv_decode_pkg::ALU_ADD, 0, 0), 0, 0, 0);
    row(0, 32'h402081b3, rr(3, 1, 2, rv_decode_pkg::ALU_SUB, 0, 0), 0, 0, 0);
    row(0, 32'hffb08193, ri(3, 1, rv_decode_pkg::ALU_ADD, rv_decode_pkg::IMM_I, 0), -5, 0, 0);
    row(0, 32'h0070b193, ri(3, 1, rv_decode_pkg::ALU_SLTU, rv_decode_pkg::IMM_I, 0), 7, 0, 0);
    row(0, 32'h4210d193, ri(3, 1, rv_decode_pkg::ALU_SRA, rv_decode_pkg::IMM_I_SHIFT, 0),
        33, 0, 0);
    row(0, 32'h002081bb, rr(3, 1, 2, rv_decode_pkg::ALU_ADD, 1, 0), 0, 0, 0);
    row(0, 32'h4050d19b, ri(3, 1, rv_decode_pkg::ALU_SRA, rv_decode_pkg::IMM_I_SHIFT, 1),
        5, 0, 0);
    row(0, 32'h0100b183, ld(rv_decode_pkg::MEM_DOUBLE, 0), 16, 0, 0);
    row(0, 32'hfff0c183, ld(rv_decode_pkg::MEM_BYTE, 1), -1, 0, 0);
    row(0, 32'h00409183, ld(rv_decode_pkg::MEM_HALF, 0), 4, 0, 0);
    row(0, 32'h0020b423, st(rv_decode_pkg::MEM_DOUBLE, 8'hff), 8, 0, 0);
    row(0, 32'hfe208e23, st(rv_decode_pkg::MEM_BYTE, 8'h01), -4, 0, 0);
    row(0, 32'h00209123, st(rv_decode_pkg::MEM_HALF, 8'h03), 2, 0, 0);
    row(0, 32'h0020a023, st(rv_decode_pkg::MEM_WORD, 8'h0f), 0, 0, 0);
    row(0, 32'h008000ef, ctl(0, 1, 0, 1, 0, 0, rv_decode_pkg::ALU_ADD,
        rv_decode_pkg::SRC_PC_FOUR, rv_decode_pkg::IMM_J), 8, 0, 0);
    row(0, 32'h004100e7, ctl(0, 1, 1, 1, 2, 0, rv_decode_pkg::ALU_ADD,
        rv_decode_pkg::SRC_PC_FOUR, rv_decode_pkg::IMM_I), 4, 0, 0);
    row(0, 32'h800001b7, ctl(0, 0, 0, 3, 0, 0, rv_decode_pkg::ALU_ADD,
        rv_decode_pkg::SRC_IMM, rv_decode_pkg::IMM_U), 64'hffffffff80000000, 0, 0);
    row(0, 32'h12345197, ctl(0, 0, 0, 3, 0, 0, rv_decode_pkg::ALU_ADD,
        rv_decode_pkg::SRC_PC_IMM, rv_decode_pkg::IMM_U), 64'h12345000, 0, 0);
    row(0, 32'h00208863, ctl(1, 0, 0, 0, 1, 2, rv_decode_pkg::ALU_EQ,
        rv_decode_pkg::SRC_REG, rv_decode_pkg::IMM_B), 16, 0, 0);
    row(0, 32'hfe20fce3, ctl(1, 0, 0, 0, 1, 2, rv_decode_pkg::ALU_GEU,
        rv_decode_pkg::SRC_REG, rv_decode_pkg::IMM_B), -8, 0, 0);
    row(0, 32'hffffffff, '0, 0, 1, 0);
    row(0, 32'h00100073, '0, 0, 0, 1);
    row(0, 32'h00000000, '0, 0, 1, 0);
    row(0, 32'h022081b3, rr(3, 1, 2, rv_decode_pkg::ALU_MUL, 0, 1), 0, 0, 0);
    row(1, 32'h00000000, '0, 0, 0, 0);   // M extension off
    row(0, 32'h022081b3, '0, 0, 1, 0);
    row(0, 32'h022081bb, '0, 0, 1, 0);
    row(0, 32'h0220d1b3, '0, 0, 1, 0);
    row(0, 32'h0220e1bb, '0, 0, 1, 0);
    row(2, 32'h00000000, '0, 0, 0, 0);
    row(0, 32'h022081b3, rr(3, 1, 2, rv_decode_pkg::ALU_MUL, 0, 1), 0, 0, 0);
    row(0, 32'h022081bb, rr(3, 1, 2, rv_decode_pkg::ALU_MUL, 1, 1), 0, 0, 0);
    row(0, 32'h0220d1b3, rr(3, 1, 2, rv_decode_pkg::ALU_DIVU, 0, 0), 0, 0, 0);
    row(0, 32'h0220e1bb, rr(3, 1, 2, rv_decode_pkg::ALU_REM, 1, 0), 0, 0, 0);
endfunction

/* tests/tb_rv_decode.sv */
`timescale 1ns/1ps

module tb_rv_decode;

    localparam int XLEN      = rv_decode_pkg::DEFAULT_XLEN;
    localparam int CNT_WIDTH = rv_decode_pkg::DEFAULT_CNT_WIDTH;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     inst_valid;
    rv_decode_pkg::inst_t     inst;
    logic                     cfg_wen;
    logic                     cfg_m_enable;
    logic                     out_valid, branch, jump, jalr, reg_wen;
    rv_decode_pkg::reg_addr_t reg_waddr, reg1_raddr, reg2_raddr;
    rv_decode_pkg::alu_op_e   alu_op;
    rv_decode_pkg::alu_src_e  alu_src;
    logic [XLEN-1:0]          imm;
    logic                     word_op, mem_read, mem_write;
    rv_decode_pkg::mem_size_e mem_size;
    logic                     load_unsigned;
    logic [7:0]               wmask;
    logic                     is_mul, ebreak, illegal;
    logic [CNT_WIDTH-1:0]     illegal_count;
    logic [CNT_WIDTH-1:0]     exp_cnt;

    `include "decode_vectors.svh"

    vec_t idle_vec;

    rv_decode_top #(.XLEN(XLEN), .CNT_WIDTH(CNT_WIDTH)) rv_decode_top_inst (.*);

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
            input logic [63:0] got);
        $display("ERROR %s expected 0x%0h got 0x%0h", name, exp, got);
        $display("SIMULATION FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_outputs(input logic exp_valid, input vec_t v);
        rv_decode_pkg::decode_ctrl_t got;
        // imm_sel has no port, take it from the expected side
        got = {branch, jump, jalr, reg_wen, reg_waddr, reg1_raddr, reg2_raddr, alu_op, alu_src,
               v.ctrl.imm_sel, word_op, mem_read, mem_write, mem_size, load_unsigned, wmask,
               is_mul};
        assert (out_valid === exp_valid) else report_mismatch("out_valid", exp_valid, out_valid);
        assert (got === v.ctrl) else report_mismatch("ctrl", v.ctrl, got);
        assert (imm === v.imm) else report_mismatch("imm", v.imm, imm);
        assert (illegal === v.illegal) else report_mismatch("illegal", v.illegal, illegal);
        assert (ebreak === v.ebreak) else report_mismatch("ebreak", v.ebreak, ebreak);
        assert (illegal_count === exp_cnt)
            else report_mismatch("illegal_count", exp_cnt, illegal_count);
        if (exp_valid && v.illegal) begin
            exp_cnt = exp_cnt + 1'b1;   // counter moves one edge later
        end
    endtask

    initial begin
        #200000;
        $display("timeout, the decode run did not finish");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h39ace07e));
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        cfg_wen      = 1'b0;
        cfg_m_enable = 1'b0;
        exp_cnt      = '0;
        idle_vec     = '0;
        build_table();
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        check_outputs(1'b0, idle_vec);
        for (int i = 0; i < vecs.size(); i++) begin
            inst_valid   = (vecs[i].cfg == 2'd0);
            inst         = vecs[i].inst;
            cfg_wen      = (vecs[i].cfg != 2'd0);
            cfg_m_enable = (vecs[i].cfg == 2'd2);
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            cfg_wen    = 1'b0;
            check_outputs(vecs[i].cfg == 2'd0, vecs[i]);
            if ($urandom_range(3) == 0) begin
                @(posedge clk);   // idle gap
                #1;
                check_outputs(1'b0, idle_vec);
            end
        end
        if (rv_decode_top_inst.rv_decode_assertions_inst.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("a bound assertion failed during the run");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

/* sources.f */
+incdir+tests
design/rv_decode_pkg.sv
design/decode_bus_if.sv
design/decode_config.sv
design/ctrl_decode.sv
design/imm_gen.sv
design/decode_out_reg.sv
design/rv_decode_top.sv
tests/rv_decode_assertions.sv
tests/tb_rv_decode.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
